//--- dv/cpuTests.svh
task automatic regAluTest();
    logic [11:0] immA;
    logic [11:0] immB;
    wordT a;
    wordT b;
    logic [4:0] sh;
    nextImm(immA);
    nextImm(immB);
    immA[11] = 1'b1;  // negative rs1 for sub and sra
    a = sext12(immA);
    b = sext12(immB);
    sh = b[4:0];
    startProgram("register alu");
    emitWithResult(encI(opImm, f3Add, 5'd1, 5'd0, immA), 5'd1, a);
    emitWithResult(encI(opImm, f3Add, 5'd2, 5'd0, immB), 5'd2, b);
    emitNops(2);  // x1 and x2 come from the register file
    emitWithResult(encR(f7Base, f3Add, 5'd3, 5'd1, 5'd2), 5'd3, a + b);
    emitWithResult(encR(f7Alt, f3Add, 5'd4, 5'd1, 5'd2), 5'd4, a - b);
    emitWithResult(encR(f7Base, f3And, 5'd5, 5'd1, 5'd2), 5'd5, a & b);
    emitWithResult(encR(f7Base, f3Or, 5'd6, 5'd1, 5'd2), 5'd6, a | b);
    emitWithResult(encR(f7Base, f3Sll, 5'd7, 5'd1, 5'd2), 5'd7, a << sh);
    emitWithResult(encR(f7Base, f3Srl, 5'd8, 5'd1, 5'd2), 5'd8, a >> sh);
    emitWithResult(encR(f7Alt, f3Srl, 5'd9, 5'd1, 5'd2), 5'd9, wordT'($signed(a) >>> sh));
    emitHalt();
    runProgram();
endtask

task automatic immAluTest();
    logic [11:0] immA;
    logic [11:0] immB;
    logic [11:0] immC;
    logic [11:0] shBits;
    wordT a;
    nextImm(immA);
    nextImm(immB);
    nextImm(immC);
    nextImm(shBits);
    immA[11] = 1'b1;
    a = sext12(immA);
    startProgram("immediate alu");
    emitWithResult(encI(opImm, f3Add, 5'd1, 5'd0, immA), 5'd1, a);
    emitNops(2);
    emitWithResult(encI(opImm, f3Add, 5'd10, 5'd1, immB), 5'd10, a + sext12(immB));
    emitWithResult(encI(opImm, f3And, 5'd11, 5'd1, immC), 5'd11, a & sext12(immC));
    emitWithResult(encI(opImm, f3Sll, 5'd12, 5'd1, {f7Base, shBits[4:0]}), 5'd12,
                   a << shBits[4:0]);
    emitWithResult(encI(opImm, f3Srl, 5'd13, 5'd1, {f7Base, shBits[9:5]}), 5'd13,
                   a >> shBits[9:5]);
    emitWithResult(encI(opImm, f3Srl, 5'd14, 5'd1, {f7Alt, immC[4:0]}), 5'd14,
                   wordT'($signed(a) >>> immC[4:0]));
    emitHalt();
    runProgram();
endtask

// same chain back to back and with two nops between steps
task automatic dependencyTest();
    logic [11:0] imm1;
    logic [11:0] imm2;
    wordT v1;
    wordT v2;
    wordT v3;
    wordT v4;
    nextImm(imm1);
    nextImm(imm2);
    v1 = sext12(imm1);
    v2 = v1 + sext12(imm2);
    v3 = v2 + v1;
    v4 = v2 - v3;
    for (int pad = 0; pad <= 2; pad += 2) begin
        startProgram(pad == 0 ? "back-to-back chain" : "padded chain");
        emitWithResult(encI(opImm, f3Add, 5'd1, 5'd0, imm1), 5'd1, v1);
        emitNops(pad);
        emitWithResult(encI(opImm, f3Add, 5'd2, 5'd1, imm2), 5'd2, v2);
        emitNops(pad);
        emitWithResult(encR(f7Base, f3Add, 5'd3, 5'd2, 5'd1), 5'd3, v3);
        emitNops(pad);
        emitWithResult(encR(f7Alt, f3Add, 5'd3, 5'd2, 5'd3), 5'd3, v4);  // x3 written twice
        emitNops(pad);
        emitWithResult(encR(f7Base, f3Or, 5'd5, 5'd3, 5'd2), 5'd5, v4 | v2);
        emitHalt();
        runProgram();
    end
endtask

task automatic memoryTest();
    logic [11:0] immV;
    logic [11:0] immK;
    logic [11:0] base;
    wordT v1;
    wordT v4;
    nextImm(immV);
    nextImm(immK);
    nextImm(base);
    base = {4'b0000, base[5:0], 2'b00};  // word aligned and below 256
    v1 = sext12(immV);
    v4 = v1 + sext12(immK);
    startProgram("store and load");
    emitWithResult(encI(opImm, f3Add, 5'd1, 5'd0, immV), 5'd1, v1);
    emitWithResult(encI(opImm, f3Add, 5'd2, 5'd0, base), 5'd2, sext12(base));
    emit(encS(5'd1, 5'd2, 12'd8));
    emitWithResult(encI(opLoad, f3Word, 5'd3, 5'd2, 12'd8), 5'd3, v1);
    emitWithResult(encI(opImm, f3Add, 5'd4, 5'd3, immK), 5'd4, v4);  // load-use
    emitWithResult(encR(f7Base, f3Add, 5'd5, 5'd3, 5'd4), 5'd5, v1 + v4);
    emit(encS(5'd4, 5'd2, 12'd12));
    emitWithResult(encI(opLoad, f3Word, 5'd6, 5'd2, 12'd12), 5'd6, v4);
    emitWithResult(encR(f7Alt, f3Add, 5'd7, 5'd6, 5'd1), 5'd7, v4 - v1);
    emit(encS(5'd6, 5'd2, 12'd16));
    emitWithResult(encI(opLoad, f3Word, 5'd8, 5'd2, 12'd16), 5'd8, v4);
    emit(encS(5'd8, 5'd2, 12'd20));  // loaded value as store data
    emitWithResult(encI(opLoad, f3Word, 5'd9, 5'd2, 12'd20), 5'd9, v4);
    emitHalt();
    runProgram();
endtask

// x1 is negative and x2 is not, so blt and bge see the sign
task automatic branchCase(logic [2:0] f3, regAddrT rs1, regAddrT rs2);
    logic [11:0] immA;
    logic [11:0] immB;
    wordT a;
    wordT b;
    wordT va;
    wordT vb;
    logic taken;
    nextImm(immA);
    nextImm(immB);
    immA[11] = 1'b1;
    immB[11] = 1'b0;
    a = sext12(immA);
    b = sext12(immB);
    va = (rs1 == 5'd1) ? a : b;
    vb = (rs2 == 5'd1) ? a : b;
    case (f3)
        f3Beq: taken = (va == vb);
        f3Bne: taken = (va != vb);
        f3Blt: taken = ($signed(va) < $signed(vb));
        default: taken = ($signed(va) >= $signed(vb));
    endcase
    startProgram($sformatf("branch f3=%0d x%0d x%0d", f3, rs1, rs2));
    emitWithResult(encI(opImm, f3Add, 5'd1, 5'd0, immA), 5'd1, a);
    emitWithResult(encI(opImm, f3Add, 5'd2, 5'd0, immB), 5'd2, b);
    emit(encB(f3, rs1, rs2, 13'd12));
    if (taken) begin
        emit(encI(opImm, f3Add, 5'd3, 5'd0, 12'd11));
        emit(encI(opImm, f3Add, 5'd4, 5'd0, 12'd22));
    end else begin
        emitWithResult(encI(opImm, f3Add, 5'd3, 5'd0, 12'd11), 5'd3, 32'd11);
        emitWithResult(encI(opImm, f3Add, 5'd4, 5'd0, 12'd22), 5'd4, 32'd22);
    end
    emitWithResult(encI(opImm, f3Add, 5'd5, 5'd0, 12'd33), 5'd5, 32'd33);
    emitHalt();
    runProgram();
endtask

task automatic branchTest();
    branchCase(f3Beq, 5'd1, 5'd1);
    branchCase(f3Beq, 5'd1, 5'd2);
    branchCase(f3Bne, 5'd1, 5'd2);
    branchCase(f3Bne, 5'd2, 5'd2);
    branchCase(f3Blt, 5'd1, 5'd2);
    branchCase(f3Blt, 5'd2, 5'd1);
    branchCase(f3Bge, 5'd2, 5'd1);
    branchCase(f3Bge, 5'd1, 5'd2);
    branchCase(f3Bge, 5'd1, 5'd1);
endtask

task automatic jalTest();
    logic [11:0] immA;
    logic [11:0] immB;
    nextImm(immA);
    nextImm(immB);
    startProgram("jal");
    emitWithResult(encI(opImm, f3Add, 5'd1, 5'd0, immA), 5'd1, sext12(immA));
    emitWithResult(encJ(5'd6, 21'd12), 5'd6, 32'd8);  // jal at pc 4
    emit(encI(opImm, f3Add, 5'd2, 5'd0, 12'd1));
    emit(encI(opImm, f3Add, 5'd3, 5'd0, 12'd2));
    emitWithResult(encI(opImm, f3Add, 5'd4, 5'd6, immB), 5'd4, 32'd8 + sext12(immB));
    emitWithResult(encJ(5'd7, 21'd8), 5'd7, 32'd24);  // jal at pc 20
    emit(encI(opImm, f3Add, 5'd8, 5'd0, 12'd3));
    emitHalt();
    runProgram();
endtask

task automatic zeroRegTest();
    startProgram("x0 writes");
    emit(encI(opImm, f3Add, 5'd0, 5'd0, 12'd123));
    emitWithResult(encI(opImm, f3Add, 5'd1, 5'd0, 12'd9), 5'd1, 32'd9);
    emitWithResult(encR(f7Base, f3Add, 5'd2, 5'd0, 5'd1), 5'd2, 32'd9);
    emitWithResult(encI(opImm, f3Add, 5'd10, 5'd0, 12'd77), 5'd10, 32'd77);
    emit(encR(f7Base, f3Add, 5'd0, 5'd10, 5'd10));
    emitWithResult(encR(f7Base, f3Add, 5'd11, 5'd0, 5'd0), 5'd11, 32'd0);
    emitHalt();
    runProgram();
    startProgram("registers after second reset");
    emitWithResult(encR(f7Base, f3Add, 5'd12, 5'd10, 5'd0), 5'd12, 32'd0);
    emitWithResult(encI(opImm, f3Add, 5'd13, 5'd1, 12'd1), 5'd13, 32'd1);
    emitWithResult(encR(f7Base, f3Add, 5'd14, 5'd11, 5'd2), 5'd14, 32'd0);
    emitHalt();
    runProgram();
endtask

//--- dv/cpuTb.sv
`default_nettype none

module cpuTb import cpuPkg::*; ();

    localparam int clkHalf = 4;
    localparam int resetCycles = 16;  // also the load window in words
    localparam int retireTimeout = 50;
    localparam int quietCycles = 20;
    localparam logic [31:0] rngSeed = 32'hf068_f8f7;
    localparam logic [2:0] f3Word = 3'b010;
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt = 7'b0100000;  // sub and sra

    logic clk;
    logic rst;
    logic imemWe;
    imemAddrT imemAddr;
    wordT imemData;
    logic retireValid;
    regAddrT retireRd;
    wordT retireData;

    logic [31:0] rngState;
    string testName;
    wordT prog[$];
    regAddrT expRd[$];
    wordT expData[$];

    cpuTop u_dut (
        .clk, .rst, .imemWe, .imemAddr, .imemData,
        .retireValid, .retireRd, .retireData
    );

    initial begin
        clk = 1'b0;
        forever #clkHalf clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic wordT sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic wordT encR(logic [6:0] f7, logic [2:0] f3, regAddrT rd, regAddrT rs1,
                                  regAddrT rs2);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic wordT encI(logic [6:0] op, logic [2:0] f3, regAddrT rd, regAddrT rs1,
                                  logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(regAddrT rs2, regAddrT rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opStore};
    endfunction

    function automatic wordT encB(logic [2:0] f3, regAddrT rs1, regAddrT rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic wordT encJ(regAddrT rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    task automatic nextImm(output logic [11:0] v);
        rngState = xorshift32(rngState);
        v = rngState[11:0];
    endtask

    task automatic reportFailure(string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkRd(regAddrT got, regAddrT exp, string what);
        if (got !== exp) begin
            reportFailure($sformatf("FAIL at %0t: %s rd got x%0d, expected x%0d",
                                    $time, what, got, exp));
        end
    endtask

    task automatic checkData(wordT got, wordT exp, string what);
        if (got !== exp) begin
            reportFailure($sformatf("FAIL at %0t: %s data got %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic startProgram(string name);
        testName = name;
        prog.delete();
        expRd.delete();
        expData.delete();
    endtask

    task automatic emit(wordT instr);
        prog.push_back(instr);
    endtask

    task automatic emitWithResult(wordT instr, regAddrT rd, wordT value);
        prog.push_back(instr);
        expRd.push_back(rd);
        expData.push_back(value);
    endtask

    task automatic emitNops(int n);
        for (int i = 0; i < n; i++) begin
            prog.push_back(nopInstr);
        end
    endtask

    task automatic emitHalt();
        prog.push_back(encJ(5'd0, 21'd0));  // jal x0 to itself
    endtask

    // unused words of the load window are filled with nops
    task automatic resetAndLoad();
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < resetCycles; i++) begin
            imemWe = 1'b1;
            imemAddr = imemAddrT'(i);
            imemData = (i < prog.size()) ? prog[i] : nopInstr;
            @(posedge clk);
            #1;
        end
        rst = 1'b0;
        imemWe = 1'b0;
    endtask

    task automatic waitRetire(output regAddrT rd, output wordT data);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > retireTimeout) begin
                reportFailure($sformatf("%s timed out waiting for a retirement", testName));
            end
        end while (!retireValid);
        rd = retireRd;
        data = retireData;
    endtask

    task automatic checkSilence();
        for (int i = 0; i < quietCycles; i++) begin
            @(negedge clk);
            if (retireValid) begin
                reportFailure($sformatf("%s retired x%0d after its last expected result",
                                        testName, retireRd));
            end
        end
    endtask

    task automatic runProgram();
        regAddrT gotRd;
        wordT gotData;
        if (prog.size() > resetCycles) begin
            reportFailure($sformatf("%s does not fit in the load window", testName));
        end
        resetAndLoad();
        for (int i = 0; i < expRd.size(); i++) begin
            waitRetire(gotRd, gotData);
            checkRd(gotRd, expRd[i], $sformatf("%s retirement %0d", testName, i));
            checkData(gotData, expData[i], $sformatf("%s retirement %0d", testName, i));
        end
        checkSilence();
    endtask

    `include "cpuTests.svh"

    initial begin
        rst = 1'b1;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        rngState = rngSeed;
        repeat (4) begin
            regAluTest();
            immAluTest();
        end
        dependencyTest();
        memoryTest();
        branchTest();
        jalTest();
        zeroRegTest();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+dv
hw/cpuPkg.sv
hw/pipeControl.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWbStage.sv
hw/cpuTop.sv
dv/cpuTb.sv

//--- hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int xlen = 32;
    localparam int imemAw = 8;  // 256 instruction words
    localparam int dmemAw = 8;  // 256 data words

    typedef logic [xlen-1:0] wordT;
    typedef logic [4:0] regAddrT;
    typedef logic [imemAw-1:0] imemAddrT;

    // major opcodes of the supported subset
    localparam logic [6:0] opReg = 7'b0110011;
    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal = 7'b1101111;

    // branch funct3 codes
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;

    // alu funct3 codes
    localparam logic [2:0] f3Add = 3'b000;
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Srl = 3'b101;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    typedef enum logic [1:0] {
        fwdNone = 2'd0,  // register file value
        fwdMem = 2'd1,   // ex/mem alu result
        fwdWb = 2'd2     // writeback value
    } fwdSelT;

    localparam wordT nopInstr = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

//--- hw/cpuTop.sv
`default_nettype none

module cpuTop import cpuPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic imemWe,
    input wire imemAddrT imemAddr,
    input wire wordT imemData,
    output logic retireValid,
    output regAddrT retireRd,
    output wordT retireData
);

    wordT idInstr, idPc;
    logic regWrite, memRead, memWrite, memToReg, aluSrc, isBranch, isJal;
    aluOpT aluOp;
    logic stall, flush, bubble;
    fwdSelT fwdA, fwdB;

    wordT exPc, exRdata1, exRdata2, exImm;
    regAddrT exRs1, exRs2, exRd;
    aluOpT exAluOp;
    logic exRegWrite, exMemRead, exMemWrite, exMemToReg;
    logic exAluSrc, exIsBranch, exIsJal;
    logic [2:0] exFunct3;

    logic redirect;
    wordT redirectPc;
    wordT memAluResult, memStoreData;
    regAddrT memRd;
    logic memRegWrite, memMemRead, memMemWrite, memMemToReg;

    wordT wbData;
    regAddrT wbRd;
    logic wbRegWrite;

    pipeControl uControl (
        .idInstr, .exRs1, .exRs2, .exRd, .exMemRead, .exRegWrite,
        .memRd, .wbRd, .memRegWrite, .wbRegWrite, .redirect,
        .regWrite, .memRead, .memWrite, .memToReg, .aluSrc, .isBranch, .isJal,
        .aluOp, .stall, .flush, .bubble, .fwdA, .fwdB
    );

    fetchStage uFetch (
        .clk, .rst, .imemWe, .imemAddr, .imemData,
        .stall, .flush, .redirect, .redirectPc, .idInstr, .idPc
    );

    decodeStage uDecode (
        .clk, .rst, .idInstr, .idPc,
        .regWrite, .memRead, .memWrite, .memToReg, .aluSrc, .isBranch, .isJal, .aluOp,
        .bubble, .wbRd, .wbData, .wbRegWrite,
        .exPc, .exRdata1, .exRdata2, .exImm, .exRs1, .exRs2, .exRd, .exAluOp,
        .exRegWrite, .exMemRead, .exMemWrite, .exMemToReg, .exAluSrc,
        .exIsBranch, .exIsJal, .exFunct3
    );

    executeStage uExecute (
        .clk, .rst, .exPc, .exRdata1, .exRdata2, .exImm, .exRd, .exAluOp,
        .exRegWrite, .exMemRead, .exMemWrite, .exMemToReg, .exAluSrc,
        .exIsBranch, .exIsJal, .exFunct3, .fwdA, .fwdB, .wbData,
        .redirect, .redirectPc, .memAluResult, .memStoreData, .memRd,
        .memRegWrite, .memMemRead, .memMemWrite, .memMemToReg
    );

    memWbStage uMemWb (
        .clk, .rst, .memAluResult, .memStoreData, .memRd,
        .memRegWrite, .memMemRead, .memMemWrite, .memMemToReg,
        .wbData, .wbRd, .wbRegWrite, .retireValid, .retireRd, .retireData
    );

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`default_nettype none

module decodeStage import cpuPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire wordT idInstr,
    input wire wordT idPc,
    input wire logic regWrite,
    input wire logic memRead,
    input wire logic memWrite,
    input wire logic memToReg,
    input wire logic aluSrc,
    input wire logic isBranch,
    input wire logic isJal,
    input wire aluOpT aluOp,
    input wire logic bubble,
    input wire regAddrT wbRd,
    input wire wordT wbData,
    input wire logic wbRegWrite,
    output wordT exPc,
    output wordT exRdata1,
    output wordT exRdata2,
    output wordT exImm,
    output regAddrT exRs1,
    output regAddrT exRs2,
    output regAddrT exRd,
    output aluOpT exAluOp,
    output logic exRegWrite,
    output logic exMemRead,
    output logic exMemWrite,
    output logic exMemToReg,
    output logic exAluSrc,
    output logic exIsBranch,
    output logic exIsJal,
    output logic [2:0] exFunct3
);

    wordT regs [32];
    regAddrT rs1, rs2;
    wordT rdata1, rdata2, imm;
    logic [6:0] opcode;

    assign rs1 = idInstr[19:15];
    assign rs2 = idInstr[24:20];
    assign opcode = idInstr[6:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRegWrite && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    // same-cycle writeback passes through
    assign rdata1 = (wbRegWrite && wbRd != '0 && wbRd == rs1) ? wbData : regs[rs1];
    assign rdata2 = (wbRegWrite && wbRd != '0 && wbRd == rs2) ? wbData : regs[rs2];

    always_comb begin
        case (opcode)
            opImm, opLoad: imm = {{21{idInstr[31]}}, idInstr[30:20]};
            opStore: imm = {{21{idInstr[31]}}, idInstr[30:25], idInstr[11:7]};
            opBranch: imm = {{20{idInstr[31]}}, idInstr[7], idInstr[30:25],
                             idInstr[11:8], 1'b0};
            opJal: imm = {{12{idInstr[31]}}, idInstr[19:12], idInstr[20],
                          idInstr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        exPc <= idPc;
        exRdata1 <= rdata1;
        exRdata2 <= rdata2;
        exImm <= imm;
        exRs1 <= rs1;
        exRs2 <= rs2;
        exRd <= idInstr[11:7];
        exFunct3 <= idInstr[14:12];
        if (rst || bubble) begin
            exAluOp <= aluAdd;
            {exRegWrite, exMemRead, exMemWrite, exMemToReg} <= '0;
            {exAluSrc, exIsBranch, exIsJal} <= '0;
        end else begin
            exAluOp <= aluOp;
            {exRegWrite, exMemRead, exMemWrite, exMemToReg} <=
                {regWrite, memRead, memWrite, memToReg};
            {exAluSrc, exIsBranch, exIsJal} <= {aluSrc, isBranch, isJal};
        end
    end

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`default_nettype none

module executeStage import cpuPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire wordT exPc,
    input wire wordT exRdata1,
    input wire wordT exRdata2,
    input wire wordT exImm,
    input wire regAddrT exRd,
    input wire aluOpT exAluOp,
    input wire logic exRegWrite,
    input wire logic exMemRead,
    input wire logic exMemWrite,
    input wire logic exMemToReg,
    input wire logic exAluSrc,
    input wire logic exIsBranch,
    input wire logic exIsJal,
    input wire logic [2:0] exFunct3,
    input wire fwdSelT fwdA,
    input wire fwdSelT fwdB,
    input wire wordT wbData,
    output logic redirect,
    output wordT redirectPc,
    output wordT memAluResult,
    output wordT memStoreData,
    output regAddrT memRd,
    output logic memRegWrite,
    output logic memMemRead,
    output logic memMemWrite,
    output logic memMemToReg
);

    wordT srcA, srcB, opB, aluOut, result;
    logic [4:0] shamt;
    logic isEq, isLt, taken;

    function automatic wordT pickFwd(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
        case (sel)
            fwdMem: return memVal;
            fwdWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = pickFwd(fwdA, exRdata1, memAluResult, wbData);
    assign srcB = pickFwd(fwdB, exRdata2, memAluResult, wbData);
    assign opB = exAluSrc ? exImm : srcB;
    assign shamt = opB[4:0];

    always_comb begin
        case (exAluOp)
            aluAdd: aluOut = srcA + opB;
            aluSub: aluOut = srcA - opB;
            aluAnd: aluOut = srcA & opB;
            aluOr: aluOut = srcA | opB;
            aluSll: aluOut = srcA << shamt;
            aluSrl: aluOut = srcA >> shamt;
            aluSra: aluOut = $signed(srcA) >>> shamt;
            default: aluOut = '0;
        endcase
    end

    assign result = exIsJal ? exPc + 32'd4 : aluOut;  // link address

    assign isEq = (srcA == srcB);
    assign isLt = ($signed(srcA) < $signed(srcB));

    always_comb begin
        case (exFunct3)
            f3Beq: taken = isEq;
            f3Bne: taken = !isEq;
            f3Blt: taken = isLt;
            f3Bge: taken = !isLt;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = (exIsBranch && taken) || exIsJal;
    assign redirectPc = exPc + exImm;

    always_ff @(posedge clk) begin
        memAluResult <= result;
        memStoreData <= srcB;
        memRd <= exRd;
        if (rst) begin
            {memRegWrite, memMemRead, memMemWrite, memMemToReg} <= '0;
        end else begin
            {memRegWrite, memMemRead, memMemWrite, memMemToReg} <=
                {exRegWrite, exMemRead, exMemWrite, exMemToReg};
        end
    end

endmodule

`default_nettype wire

//--- hw/fetchStage.sv
`default_nettype none

module fetchStage import cpuPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic imemWe,
    input wire imemAddrT imemAddr,
    input wire wordT imemData,
    input wire logic stall,
    input wire logic flush,
    input wire logic redirect,
    input wire wordT redirectPc,
    output wordT idInstr,
    output wordT idPc
);

    wordT imem [2**imemAw];
    wordT pc;
    imemAddrT pcIdx;

    assign pcIdx = pc[imemAw+1:2];  // word index

    // load port is driven while rst is high
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idInstr <= nopInstr;
        end else if (flush || redirect) begin
            idInstr <= nopInstr;  // squash wrong-path fetch
        end else if (!stall) begin
            idInstr <= imem[pcIdx];
            idPc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- hw/memWbStage.sv
`default_nettype none

module memWbStage import cpuPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire wordT memAluResult,
    input wire wordT memStoreData,
    input wire regAddrT memRd,
    input wire logic memRegWrite,
    input wire logic memMemRead,
    input wire logic memMemWrite,
    input wire logic memMemToReg,
    output wordT wbData,
    output regAddrT wbRd,
    output logic wbRegWrite,
    output logic retireValid,
    output regAddrT retireRd,
    output wordT retireData
);

    wordT dmem [2**dmemAw];
    logic [dmemAw-1:0] dIdx;
    wordT readData;
    wordT wbAluResult, wbLoadData;
    logic wbMemToReg;

    assign dIdx = memAluResult[dmemAw+1:2];  // word aligned
    assign readData = dmem[dIdx];

    always_ff @(posedge clk) begin
        if (memMemWrite) begin
            dmem[dIdx] <= memStoreData;
        end
    end

    always_ff @(posedge clk) begin
        wbAluResult <= memAluResult;
        wbRd <= memRd;
        if (memMemRead) begin
            wbLoadData <= readData;
        end
        if (rst) begin
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbMemToReg <= memMemToReg;
        end
    end

    assign wbData = wbMemToReg ? wbLoadData : wbAluResult;

    // x0 writes are not architectural
    assign retireValid = wbRegWrite && (wbRd != '0);
    assign retireRd = wbRd;
    assign retireData = wbData;

endmodule

`default_nettype wire

//--- hw/pipeControl.sv
`default_nettype none

module pipeControl import cpuPkg::*; (
    input wire wordT idInstr,
    input wire regAddrT exRs1,
    input wire regAddrT exRs2,
    input wire regAddrT exRd,
    input wire logic exMemRead,
    input wire logic exRegWrite,
    input wire regAddrT memRd,
    input wire regAddrT wbRd,
    input wire logic memRegWrite,
    input wire logic wbRegWrite,
    input wire logic redirect,
    output logic regWrite,
    output logic memRead,
    output logic memWrite,
    output logic memToReg,
    output logic aluSrc,
    output logic isBranch,
    output logic isJal,
    output aluOpT aluOp,
    output logic stall,
    output logic flush,
    output logic bubble,
    output fwdSelT fwdA,
    output fwdSelT fwdB
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic alt;  // funct7 bit 30
    regAddrT idRs1, idRs2;
    logic useRs1, useRs2;

    assign opcode = idInstr[6:0];
    assign funct3 = idInstr[14:12];
    assign alt = idInstr[30];
    assign idRs1 = idInstr[19:15];
    assign idRs2 = idInstr[24:20];

    assign regWrite = (opcode == opReg) || (opcode == opImm) || (opcode == opLoad)
                    || (opcode == opJal);
    assign memRead = (opcode == opLoad);
    assign memToReg = (opcode == opLoad);
    assign memWrite = (opcode == opStore);
    assign aluSrc = (opcode == opImm) || (opcode == opLoad) || (opcode == opStore);
    assign isBranch = (opcode == opBranch);
    assign isJal = (opcode == opJal);

    always_comb begin
        aluOp = aluAdd;  // loads, stores and addi
        if (opcode == opReg || opcode == opImm) begin
            case (funct3)
                f3Add: aluOp = (opcode == opReg && alt) ? aluSub : aluAdd;
                f3And: aluOp = aluAnd;
                f3Or: aluOp = aluOr;
                f3Sll: aluOp = aluSll;
                f3Srl: aluOp = alt ? aluSra : aluSrl;
                default: aluOp = aluAdd;
            endcase
        end
    end

    // only real source operands can cause a load-use stall
    assign useRs1 = (opcode != opJal);
    assign useRs2 = (opcode == opReg) || (opcode == opStore) || (opcode == opBranch);

    assign stall = exMemRead && exRegWrite && (exRd != '0)
                 && ((useRs1 && exRd == idRs1) || (useRs2 && exRd == idRs2));

    assign flush = redirect;
    assign bubble = stall || redirect;

    always_comb begin
        fwdA = fwdNone;
        fwdB = fwdNone;
        if (memRegWrite && memRd != '0 && memRd == exRs1) fwdA = fwdMem;  // youngest first
        else if (wbRegWrite && wbRd != '0 && wbRd == exRs1) fwdA = fwdWb;
        if (memRegWrite && memRd != '0 && memRd == exRs2) fwdB = fwdMem;
        else if (wbRegWrite && wbRd != '0 && wbRd == exRs2) fwdB = fwdWb;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module cpuTb -f flist.f -o cpuSim > sim.log 2>&1 \
    && ./obj_dir/cpuSim >> sim.log 2>&1 \
    || echo "Some tests failed" >> sim.log
cat sim.log
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
